// File: alu_board_top.f
+incdir+.
alu_pkg.sv
input_sync.sv
operand_capture.sv
alu_execute.sv
alu_board_top.sv
alu_board_assertions.sv
tb_alu_board.sv

// File: Makefile
TOP := tb_alu_board

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f alu_board_top.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: tb_alu_board.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module tb_alu_board;

	////////////////////////////////////////////////////////////
	// Constants and types
	////////////////////////////////////////////////////////////

	localparam int W = `ALU_DATA_WIDTH;
	// Reset, directed, random, unknown code and held button checks
	localparam int NUM_TESTS = 215;
	localparam int CYCLE_LIMIT = 40 * NUM_TESTS + 100;
	// Cycles from opcode press to led sample
	localparam int CHECK_DELAY = 6;
	// Button selectors
	localparam int BTN_A = 0;
	localparam int BTN_B = 1;
	localparam int BTN_OP = 2;

	// MIPS funct field values
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_ADD = 6'b100000;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_SUB = 6'b100010;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_AND = 6'b100100;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_OR = 6'b100101;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_XOR = 6'b100110;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_NOR = 6'b100111;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_SRL = 6'b000010;
	localparam logic [`ALU_FUNCT_WIDTH-1:0] F_SRA = 6'b000011;

	// Pending led check
	typedef struct packed {
		int           due;
		logic [W-1:0] expected;
	} check_t;

	// DUT pins
	logic         clk100mhz;
	logic         reset;
	logic [W-1:0] sw;
	logic         but_izq;
	logic         but_center;
	logic         sw_op;
	logic [W-1:0] led;

	// Run bookkeeping
	int     cycle = 0;
	int     issued;
	int     checked;
	int     fail_count;
	int     seed_value;
	check_t check_q[$];
	string  name_q[$];
	// Operands the DUT should hold right now
	logic [W-1:0] model_a;
	logic [W-1:0] model_b;
	logic [`ALU_FUNCT_WIDTH-1:0] valid_codes [8] = '{F_ADD, F_SUB, F_AND, F_OR,
		F_XOR, F_NOR, F_SRL, F_SRA};

	alu_board_top uut (
		.sw         (sw),
		.but_izq    (but_izq),
		.but_center (but_center),
		.sw_op      (sw_op),
		.clk100mhz  (clk100mhz),
		.reset      (reset),
		.led        (led)
	);

	////////////////////////////////////////////////////////////
	// Clock, cycle count, timeout
	////////////////////////////////////////////////////////////

	initial begin
		clk100mhz = 1'b0;
		forever #4 clk100mhz = ~clk100mhz;
	end

	always @(posedge clk100mhz) begin
		cycle <= cycle + 1;
	end

	initial begin
		wait (cycle >= CYCLE_LIMIT);
		$display("run timed out after %0d cycles with %0d checks still open", cycle,
			issued - checked);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [W-1:0] ref_alu(
		input logic [W-1:0]                  a,
		input logic [W-1:0]                  b,
		input logic [`ALU_FUNCT_WIDTH-1:0] funct
	);
		logic [W-1:0] r;
		int           steps;
		// Past the word width nothing more changes
		steps = (int'(b) < W) ? int'(b) : W;
		r = '0;
		case (funct)
			F_ADD: r = a + b;
			F_SUB: r = a - b;
			F_AND: r = a & b;
			F_OR: r = a | b;
			F_XOR: r = a ^ b;
			F_NOR: r = ~(a | b);
			// One bit per step, zero fill
			F_SRL: begin
				r = a;
				for (int k = 0; k < steps; k++) begin
					r = {1'b0, r[W-1:1]};
				end
			end
			// One bit per step, sign fill
			F_SRA: begin
				r = a;
				for (int k = 0; k < steps; k++) begin
					r = {r[W-1], r[W-1:1]};
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus tasks, all start and end on a falling edge
	////////////////////////////////////////////////////////////

	task automatic drive_button(input int btn, input logic level);
		case (btn)
			BTN_A: but_izq = level;
			BTN_B: but_center = level;
			default: sw_op = level;
		endcase
	endtask

	// Hold for some cycles, then 2 cycles released
	task automatic press_button(input int btn, input logic [W-1:0] value, input int hold);
		sw = value;
		drive_button(btn, 1'b1);
		repeat (hold) @(negedge clk100mhz);
		drive_button(btn, 1'b0);
		repeat (2) @(negedge clk100mhz);
	endtask

	task automatic expect_led(input string name, input logic [W-1:0] expected);
		check_t rec;
		rec.due = cycle + CHECK_DELAY;
		rec.expected = expected;
		check_q.push_back(rec);
		name_q.push_back(name);
		issued++;
	endtask

	task automatic load_operand_a(input logic [W-1:0] value);
		model_a = value;
		press_button(BTN_A, value, 2);
	endtask

	task automatic load_operand_b(input logic [W-1:0] value);
		model_b = value;
		press_button(BTN_B, value, 2);
	endtask

	// Pad bits are random, the DUT drops them
	task automatic load_opcode(input string name, input logic [`ALU_FUNCT_WIDTH-1:0] funct);
		logic [1:0] pad;
		pad = 2'($urandom);
		expect_led(name, ref_alu(model_a, model_b, funct));
		press_button(BTN_OP, {pad, funct}, 2);
	endtask

	task automatic run_op(input string name, input logic [W-1:0] a, input logic [W-1:0] b,
		input logic [`ALU_FUNCT_WIDTH-1:0] funct);
		load_operand_a(a);
		load_operand_b(b);
		load_opcode(name, funct);
	endtask

	// Listed result must also agree with the model
	task automatic run_directed(input string name, input logic [W-1:0] a,
		input logic [W-1:0] b, input logic [`ALU_FUNCT_WIDTH-1:0] funct,
		input logic [W-1:0] listed);
		assert (ref_alu(a, b, funct) == listed) else begin
			$display("reference model disagrees with the listed result %h in %s", listed, name);
			fail_count++;
		end
		run_op(name, a, b, funct);
	endtask

	task automatic drain_checks();
		wait (checked == issued);
	endtask

	// Long press, switches move while held
	task automatic hold_opcode_test();
		load_operand_a(8'hC3);
		load_operand_b(8'h05);
		expect_led("held_opcode", ref_alu(model_a, model_b, F_ADD));
		sw = {2'b00, F_ADD};
		sw_op = 1'b1;
		repeat (4) @(negedge clk100mhz);
		// Would give C6 if captured again
		sw = {2'b00, F_XOR};
		repeat (6) @(negedge clk100mhz);
		sw_op = 1'b0;
		expect_led("held_no_repeat", ref_alu(model_a, model_b, F_ADD));
		repeat (2) @(negedge clk100mhz);
		drain_checks();
		load_opcode("opcode_only", F_NOR);
	endtask

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	initial begin : compare_results
		check_t rec;
		string  name;
		logic   ok;
		forever begin
			wait (issued > checked);
			rec = check_q.pop_front();
			name = name_q.pop_front();
			while (cycle < rec.due) @(negedge clk100mhz);
			ok = (led === rec.expected);
			assert (ok) else begin
				$display("error %s expected %h actual %h", name, rec.expected, led);
				fail_count++;
			end
			if (ok) begin
				$display("pass %s led %h", name, led);
			end
			checked++;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin : main_sequence
		logic [W-1:0]                  rand_a;
		logic [W-1:0]                  rand_b;
		logic [2:0]                    idx;
		int                            violations;
		seed_value = $urandom(36317);
		reset = 1'b1;
		sw = '0;
		but_izq = 1'b0;
		but_center = 1'b0;
		sw_op = 1'b0;
		issued = 0;
		checked = 0;
		fail_count = 0;
		model_a = '0;
		model_b = '0;
		// Three rising edges in reset
		repeat (3) @(posedge clk100mhz);
		@(negedge clk100mhz);
		reset = 1'b0;

		// Idle after reset
		expect_led("reset_led_zero", '0);
		drain_checks();

		// Directed vectors
		run_directed("add_1_2", 8'h01, 8'h02, F_ADD, 8'h03);
		run_directed("add_wrap", 8'h7F, 8'h01, F_ADD, 8'h80);
		run_directed("sub_3_5", 8'h03, 8'h05, F_SUB, 8'hFE);
		run_directed("and_ff_0f", 8'hFF, 8'h0F, F_AND, 8'h0F);
		run_directed("or_01_0f", 8'h01, 8'h0F, F_OR, 8'h0F);
		run_directed("xor_ff_0f", 8'hFF, 8'h0F, F_XOR, 8'hF0);
		run_directed("sra_88_2", 8'h88, 8'h02, F_SRA, 8'hE2);
		run_directed("srl_100_2", 8'd100, 8'd2, F_SRL, 8'd25);
		run_directed("nor_0f_03", 8'h0F, 8'h03, F_NOR, 8'hF0);

		// Random pairs, half with small shift amounts around the width
		for (int i = 0; i < 200; i++) begin
			idx = 3'($urandom);
			rand_a = W'($urandom);
			rand_b = W'($urandom);
			if ($urandom_range(1, 0) == 0) begin
				rand_b = W'($urandom_range(11, 0));
			end
			run_op($sformatf("random_%0d", i), rand_a, rand_b, valid_codes[idx]);
		end

		// Unknown code, then stored operands reused
		run_directed("unknown_funct", 8'h5A, 8'h33, 6'b111111, 8'h00);
		load_opcode("reuse_operands", F_SUB);

		hold_opcode_test();
		drain_checks();

		violations = uut.u_assertions.violation_count;
		$display("%0d tests run, %0d failed, %0d assertion failures", checked, fail_count,
			violations);
		if (fail_count == 0 && violations == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: alu_board_assertions.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_board_assertions (
	input logic                       clk100mhz,
	input logic                       reset,
	input alu_pkg::load_strobes_t     strobes,
	input alu_pkg::alu_req_t          req,
	input logic [`ALU_DATA_WIDTH-1:0] led
);

	// Failures seen so far
	int violation_count = 0;

	////////////////////////////////////////////////////////////
	// Strobes into operand_capture
	////////////////////////////////////////////////////////////

	// Edge detector output, never two cycles in a row
	load_a_single: assert property (@(posedge clk100mhz) disable iff (reset)
		strobes.load_a |=> !strobes.load_a)
	else begin
		violation_count++;
		$error("load_a strobe stayed high for two cycles");
	end

	load_b_single: assert property (@(posedge clk100mhz) disable iff (reset)
		strobes.load_b |=> !strobes.load_b)
	else begin
		violation_count++;
		$error("load_b strobe stayed high for two cycles");
	end

	load_op_single: assert property (@(posedge clk100mhz) disable iff (reset)
		strobes.load_op |=> !strobes.load_op)
	else begin
		violation_count++;
		$error("load_op strobe stayed high for two cycles");
	end

	////////////////////////////////////////////////////////////
	// Request and LED register
	////////////////////////////////////////////////////////////

	// Valid exactly one cycle behind the opcode strobe
	valid_after_op: assert property (@(posedge clk100mhz) disable iff (reset)
		strobes.load_op |=> req.valid)
	else begin
		violation_count++;
		$error("request valid missing one cycle after load_op");
	end

	valid_only_after_op: assert property (@(posedge clk100mhz) disable iff (reset)
		req.valid |-> $past(strobes.load_op))
	else begin
		violation_count++;
		$error("request valid without a load_op strobe the cycle before");
	end

	// LED register holds between requests
	led_after_valid: assert property (@(posedge clk100mhz) disable iff (reset)
		!$stable(led) |-> $past(req.valid))
	else begin
		violation_count++;
		$error("led changed without a request in the cycle before");
	end

endmodule

// Watches the links into and out of operand_capture and alu_execute
bind alu_board_top alu_board_assertions u_assertions (
	.clk100mhz (clk100mhz),
	.reset     (reset),
	.strobes   (strobes),
	.req       (req),
	.led       (led)
);

// File: alu_board_top.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_board_top (
	input  logic [`ALU_DATA_WIDTH-1:0] sw,
	input  logic                       but_izq,
	input  logic                       but_center,
	input  logic                       sw_op,
	input  logic                       clk100mhz,
	input  logic                       reset,
	output logic [`ALU_DATA_WIDTH-1:0] led
);

	////////////////////////////////////////////////////////////
	// Stage links
	////////////////////////////////////////////////////////////

	// Pulses and synchronized switches
	alu_pkg::load_strobes_t strobes;
	// Operands plus function code
	alu_pkg::alu_req_t      req;

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	// Stage 1, buttons to pulses
	input_sync u_input_sync (
		.clk100mhz  (clk100mhz),
		.reset      (reset),
		.sw         (sw),
		.but_izq    (but_izq),
		.but_center (but_center),
		.sw_op      (sw_op),
		.strobes    (strobes)
	);

	// Stage 2, operand and opcode registers
	operand_capture u_operand_capture (
		.clk100mhz (clk100mhz),
		.reset     (reset),
		.strobes   (strobes),
		.req       (req)
	);

	// Stage 3, ALU and LED register
	alu_execute u_alu_execute (
		.clk100mhz (clk100mhz),
		.reset     (reset),
		.req       (req),
		.led       (led)
	);

endmodule

// File: alu_execute.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_execute (
	input  logic                       clk100mhz,
	input  logic                       reset,
	input  alu_pkg::alu_req_t          req,
	output logic [`ALU_DATA_WIDTH-1:0] led
);

	// Local names for the operands
	logic [`ALU_DATA_WIDTH-1:0] a;
	logic [`ALU_DATA_WIDTH-1:0] b;
	// Shift amount too large for the word
	logic                       shift_sat;
	// Combinational ALU output
	logic [`ALU_DATA_WIDTH-1:0] result;

	assign a = req.operand_a;
	assign b = req.operand_b;

	// Whole of B is the amount, not just its low bits
	assign shift_sat = (b >= `ALU_DATA_WIDTH'(`ALU_DATA_WIDTH));

	////////////////////////////////////////////////////////////
	// Function decode
	////////////////////////////////////////////////////////////

	always_comb begin
		result = '0;
		case (req.funct)
			// Wraps modulo 2^width, no carry kept
			alu_pkg::FUNCT_ADD: begin
				result = a + b;
			end
			alu_pkg::FUNCT_SUB: begin
				result = a - b;
			end
			// Bitwise group
			alu_pkg::FUNCT_AND: begin
				result = a & b;
			end
			alu_pkg::FUNCT_OR: begin
				result = a | b;
			end
			alu_pkg::FUNCT_XOR: begin
				result = a ^ b;
			end
			alu_pkg::FUNCT_NOR: begin
				result = ~(a | b);
			end
			// Logical shift, zeros come in from the top
			alu_pkg::FUNCT_SRL: begin
				if (shift_sat) begin
					result = '0;
				end else begin
					result = a >> b;
				end
			end
			// Arithmetic shift
			// Saturates to copies of the sign bit
			alu_pkg::FUNCT_SRA: begin
				if (shift_sat) begin
					result = {`ALU_DATA_WIDTH{a[`ALU_DATA_WIDTH-1]}};
				end else begin
					result = $signed(a) >>> b;
				end
			end
			// Unknown code reads as zero
			default: begin
				result = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// LED register
	////////////////////////////////////////////////////////////

	// Loads only on a request
	// Otherwise shows the last result
	always_ff @(posedge clk100mhz) begin
		if (reset) begin
			led <= '0;
		end else if (req.valid) begin
			led <= result;
		end
	end

endmodule

// File: operand_capture.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module operand_capture (
	input  logic                   clk100mhz,
	input  logic                   reset,
	input  alu_pkg::load_strobes_t strobes,
	output alu_pkg::alu_req_t      req
);

	// Stored operands
	logic [`ALU_DATA_WIDTH-1:0] operand_a_q;
	logic [`ALU_DATA_WIDTH-1:0] operand_b_q;
	// Last loaded function code
	alu_pkg::funct_e            funct_q;
	// Request pulse, one per opcode load
	logic                       valid_q;

	////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////

	// Switch word read as plain data here
	always_ff @(posedge clk100mhz) begin
		if (reset) begin
			operand_a_q <= '0;
			operand_b_q <= '0;
		end else begin
			// Left button
			if (strobes.load_a) begin
				operand_a_q <= strobes.sw.data;
			end
			// Center button
			if (strobes.load_b) begin
				operand_b_q <= strobes.sw.data;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Opcode register and request
	////////////////////////////////////////////////////////////

	// Switch word read as an opcode here
	// Pad bits dropped
	always_ff @(posedge clk100mhz) begin
		if (reset) begin
			funct_q <= alu_pkg::funct_e'('0);
			valid_q <= 1'b0;
		end else begin
			if (strobes.load_op) begin
				funct_q <= strobes.sw.op.funct;
			end
			// Valid in the cycle after the strobe
			valid_q <= strobes.load_op;
		end
	end

	// Request bundle
	// A and B are whatever is held at the moment
	assign req.valid     = valid_q;
	assign req.operand_a = operand_a_q;
	assign req.operand_b = operand_b_q;
	assign req.funct     = funct_q;

endmodule

// File: input_sync.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module input_sync (
	input  logic                       clk100mhz,
	input  logic                       reset,
	input  logic [`ALU_DATA_WIDTH-1:0] sw,
	input  logic                       but_izq,
	input  logic                       but_center,
	input  logic                       sw_op,
	output alu_pkg::load_strobes_t     strobes
);

	// Button vectors ordered as {izq, center, op}
	logic [2:0]                 btn_meta;
	logic [2:0]                 btn_sync;
	logic [2:0]                 btn_prev;
	logic [2:0]                 btn_pulse;
	// Switch word synchronizer
	logic [`ALU_DATA_WIDTH-1:0] sw_meta;
	logic [`ALU_DATA_WIDTH-1:0] sw_sync;

	////////////////////////////////////////////////////////////
	// Synchronizers
	////////////////////////////////////////////////////////////

	// Free running through reset
	// Edge history follows a held button, so no pulse fires on release of reset
	always_ff @(posedge clk100mhz) begin
		btn_meta <= {but_izq, but_center, sw_op};
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
		sw_meta  <= sw;
		sw_sync  <= sw_meta;
	end

	////////////////////////////////////////////////////////////
	// Rising edge pulses
	////////////////////////////////////////////////////////////

	// One cycle high on a low to high step
	// Holding a button gives nothing more
	always_ff @(posedge clk100mhz) begin
		if (reset) begin
			btn_pulse <= '0;
		end else begin
			btn_pulse <= btn_sync & ~btn_prev;
		end
	end

	// Pulses plus the synchronized switch word
	assign strobes.load_a  = btn_pulse[2];
	assign strobes.load_b  = btn_pulse[1];
	assign strobes.load_op = btn_pulse[0];
	assign strobes.sw.data = sw_sync;

endmodule

// File: alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

	////////////////////////////////////////////////////////////
	// Function codes
	////////////////////////////////////////////////////////////

	// R-type funct field values
	typedef enum logic [`ALU_FUNCT_WIDTH-1:0] {
		FUNCT_ADD = 6'b100000,
		FUNCT_SUB = 6'b100010,
		FUNCT_AND = 6'b100100,
		FUNCT_OR  = 6'b100101,
		FUNCT_XOR = 6'b100110,
		FUNCT_NOR = 6'b100111,
		FUNCT_SRL = 6'b000010,
		FUNCT_SRA = 6'b000011
	} funct_e;

	// Switch word seen as an opcode
	// Upper bits are unused padding
	typedef struct packed {
		logic [`ALU_DATA_WIDTH-`ALU_FUNCT_WIDTH-1:0] pad;
		funct_e                                      funct;
	} sw_opcode_t;

	// Same switch word, operand view or opcode view
	typedef union packed {
		logic [`ALU_DATA_WIDTH-1:0] data;
		sw_opcode_t                 op;
	} sw_word_u;

	////////////////////////////////////////////////////////////
	// Stage links
	////////////////////////////////////////////////////////////

	// Sync stage to capture stage
	typedef struct packed {
		logic     load_a;
		logic     load_b;
		logic     load_op;
		sw_word_u sw;
	} load_strobes_t;

	// Capture stage to execute stage
	typedef struct packed {
		logic                       valid;
		logic [`ALU_DATA_WIDTH-1:0] operand_a;
		logic [`ALU_DATA_WIDTH-1:0] operand_b;
		funct_e                     funct;
	} alu_req_t;

endpackage

// File: alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Board data path width
// Switches, operands and LEDs share it
`define ALU_DATA_WIDTH 8

// MIPS-style function code width
`define ALU_FUNCT_WIDTH 6

`endif
